// File: source/isaPkg.sv
package isaPkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OpReg    = 7'b0110011,
        OpImm    = 7'b0010011,
        OpLoad   = 7'b0000011,
        OpStore  = 7'b0100011,
        OpBranch = 7'b1100011,
        OpSystem = 7'b1110011
    } opcodeT;

    typedef enum logic [2:0] {
        AluAdd = 3'd0,
        AluSub = 3'd1,
        AluAnd = 3'd2,
        AluOr  = 3'd3,
        AluXor = 3'd4,
        AluSlt = 3'd5
    } aluOpT;

    // funct3 codes
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Word   = 3'b010;
    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Bne    = 3'b001;

    // funct7 codes
    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Sub  = 7'b0100000;

    localparam logic [31:0] ebreakWord = 32'h0010_0073;

endpackage

// File: source/corePkg.sv
package corePkg;

    localparam int xlen        = 32;
    localparam int regAddrBits = 5;

    // Unified code and data memory
    localparam int memWords    = 256;
    localparam int memAddrBits = 8;

    localparam logic [31:0] resetPc = 32'h0000_0000;

    // Phases of the multicycle sequence
    typedef enum logic [2:0] {
        Idle      = 3'd0,
        Fetch     = 3'd1,
        Decode    = 3'd2,
        Execute   = 3'd3,
        Memory    = 3'd4,
        WriteBack = 3'd5,
        Halted    = 3'd6
    } coreStateT;

endpackage

// File: source/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic [corePkg::regAddrBits-1:0] rs1,
    input  logic [corePkg::regAddrBits-1:0] rs2,
    input  logic [corePkg::regAddrBits-1:0] rd,
    input  logic                            regWrite,
    input  logic                            memToReg,
    input  logic [corePkg::xlen-1:0]        aluResult,
    input  logic [corePkg::xlen-1:0]        memData,
    output logic [corePkg::xlen-1:0]        readData1,
    output logic [corePkg::xlen-1:0]        readData2,
    input  logic [corePkg::regAddrBits-1:0] dbgAddr,
    output logic [corePkg::xlen-1:0]        dbgData
);

    localparam int numRegs = 2 ** corePkg::regAddrBits;

    logic [corePkg::xlen-1:0] regs [numRegs];

    // Both read ports are sampled on every edge
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
            readData1 <= '0;
            readData2 <= '0;
        end else begin
            readData1 <= (rs1 == '0) ? '0 : regs[rs1];
            readData2 <= (rs2 == '0) ? '0 : regs[rs2];
            // x0 stays zero
            if (regWrite && (rd != '0)) begin
                regs[rd] <= memToReg ? memData : aluResult;
            end
        end
    end

    assign dbgData = (dbgAddr == '0) ? '0 : regs[dbgAddr];

endmodule

// File: source/alu.sv
`timescale 1ns/1ps

module alu (
    input  isaPkg::aluOpT            op,
    input  logic [corePkg::xlen-1:0] a,
    input  logic [corePkg::xlen-1:0] b,
    output logic [corePkg::xlen-1:0] result,
    output logic                     zero
);

    always_comb begin
        case (op)
            isaPkg::AluAdd: begin
                result = a + b;
            end
            isaPkg::AluSub: begin
                result = a - b;
            end
            isaPkg::AluAnd: begin
                result = a & b;
            end
            isaPkg::AluOr: begin
                result = a | b;
            end
            isaPkg::AluXor: begin
                result = a ^ b;
            end
            isaPkg::AluSlt: begin
                // Signed compare
                result = {{(corePkg::xlen - 1){1'b0}}, ($signed(a) < $signed(b))};
            end
            default: begin
                result = a + b;
            end
        endcase
    end

    // Branch decision uses this after a subtract
    assign zero = (result == '0);

endmodule

// File: source/instrDecode.sv
`timescale 1ns/1ps

module instrDecode (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic                            irLoad,
    input  logic [corePkg::xlen-1:0]        memData,
    output logic [corePkg::regAddrBits-1:0] rs1,
    output logic [corePkg::regAddrBits-1:0] rs2,
    output logic [corePkg::regAddrBits-1:0] rd,
    output isaPkg::opcodeT                  opcode,
    output logic [corePkg::xlen-1:0]        imm,
    output isaPkg::aluOpT                   aluOpSel,
    output logic                            branchNe,
    output logic                            isEbreak
);

    logic [corePkg::xlen-1:0] ir;
    logic [corePkg::xlen-1:0] instr;
    logic [2:0]               funct3;
    logic [6:0]               funct7;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ir <= '0;
        end else if (irLoad) begin
            ir <= memData;
        end
    end

    // During Decode the fields come straight from the fetched word
    assign instr  = irLoad ? memData : ir;

    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign opcode = isaPkg::opcodeT'(instr[6:0]);

    assign branchNe = (funct3 == isaPkg::f3Bne);
    assign isEbreak = (instr == isaPkg::ebreakWord);

    // --------------------
    // Immediates
    always_comb begin
        case (opcode)
            isaPkg::OpStore: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            isaPkg::OpBranch: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            default: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
        endcase
    end

    // --------------------
    // ALU operation
    always_comb begin
        aluOpSel = isaPkg::AluAdd;
        if (opcode == isaPkg::OpBranch) begin
            aluOpSel = isaPkg::AluSub;
        end else if (opcode == isaPkg::OpReg) begin
            case (funct3)
                isaPkg::f3AddSub: begin
                    aluOpSel = (funct7 == isaPkg::f7Sub) ? isaPkg::AluSub : isaPkg::AluAdd;
                end
                isaPkg::f3And: aluOpSel = isaPkg::AluAnd;
                isaPkg::f3Or:  aluOpSel = isaPkg::AluOr;
                isaPkg::f3Xor: aluOpSel = isaPkg::AluXor;
                isaPkg::f3Slt: aluOpSel = isaPkg::AluSlt;
                default:       aluOpSel = isaPkg::AluAdd;
            endcase
        end
    end

endmodule

// File: source/pcCounter.sv
`timescale 1ns/1ps

module pcCounter (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic                     pcInc,
    input  logic                     pcBranch,
    input  logic                     retire,
    input  logic [corePkg::xlen-1:0] branchTarget,
    output logic [corePkg::xlen-1:0] pc,
    output logic [corePkg::xlen-1:0] retired
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc      <= corePkg::resetPc;
            retired <= '0;
        end else begin
            // Taken branch wins over the increment
            if (pcBranch) begin
                pc <= branchTarget;
            end else if (pcInc) begin
                pc <= pc + 32'd4;
            end
            if (retire) begin
                retired <= retired + 1'b1;
            end
        end
    end

endmodule

// File: source/unifiedMemory.sv
`timescale 1ns/1ps

module unifiedMemory (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic [corePkg::xlen-1:0]        addr,
    input  logic                            we,
    input  logic [corePkg::xlen-1:0]        wdata,
    output logic [corePkg::xlen-1:0]        rdata,
    input  logic                            progWe,
    input  logic [corePkg::memAddrBits-1:0] progAddr,
    input  logic [corePkg::xlen-1:0]        progData
);

    logic [corePkg::xlen-1:0]        mem [corePkg::memWords];
    logic [corePkg::memAddrBits-1:0] wordIdx;

    // Byte address to word index
    assign wordIdx = addr[corePkg::memAddrBits+1:2];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < corePkg::memWords; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else begin
            rdata <= mem[wordIdx];
            // Load port has priority
            if (progWe) begin
                mem[progAddr] <= progData;
            end else if (we) begin
                mem[wordIdx] <= wdata;
            end
        end
    end

endmodule

// File: source/controlFsm.sv
`timescale 1ns/1ps

module controlFsm (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic                     start,
    input  isaPkg::opcodeT           opcode,
    input  logic                     isEbreak,
    input  logic                     aluZero,
    input  logic                     branchNe,
    input  logic [corePkg::xlen-1:0] aluResult,
    input  logic [corePkg::xlen-1:0] pc,
    input  logic [corePkg::xlen-1:0] imm,
    input  logic [corePkg::xlen-1:0] readData1,
    output logic [corePkg::xlen-1:0] memAddr,
    output logic                     memWe,
    output logic                     irLoad,
    output logic                     regWrite,
    output logic                     memToReg,
    output logic                     aluSrcImm,
    output logic                     pcInc,
    output logic                     pcBranch,
    output logic                     retire,
    output logic [corePkg::xlen-1:0] aluOutReg,
    output logic [corePkg::xlen-1:0] branchTarget,
    output logic                     halted,
    output logic                     illegal
);

    corePkg::coreStateT state;
    corePkg::coreStateT nextState;
    logic               badOp;
    logic               isMemOp;
    logic               taken;

    assign isMemOp = (opcode == isaPkg::OpLoad) || (opcode == isaPkg::OpStore);
    assign taken   = branchNe ? !aluZero : aluZero;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state   <= corePkg::Idle;
            illegal <= 1'b0;
        end else begin
            state <= nextState;
            if (badOp) begin
                illegal <= 1'b1;
            end
        end
    end

    // --------------------
    // Datapath registers
    always_ff @(posedge clk) begin
        if (state == corePkg::Decode) begin
            branchTarget <= pc + imm;
        end
        // Loads and stores get their effective address from the ALU add
        if (state == corePkg::Execute) begin
            aluOutReg <= aluResult;
        end
    end

    // --------------------
    // Sequencing and strobes
    always_comb begin
        nextState = state;
        badOp     = 1'b0;
        memAddr   = pc;
        memWe     = 1'b0;
        irLoad    = 1'b0;
        regWrite  = 1'b0;
        memToReg  = 1'b0;
        aluSrcImm = 1'b0;
        pcInc     = 1'b0;
        pcBranch  = 1'b0;
        retire    = 1'b0;
        case (state)
            corePkg::Idle: begin
                if (start) begin
                    nextState = corePkg::Fetch;
                end
            end
            corePkg::Fetch: begin
                nextState = corePkg::Decode;
            end
            corePkg::Decode: begin
                irLoad = 1'b1;
                case (opcode)
                    isaPkg::OpReg, isaPkg::OpImm, isaPkg::OpLoad,
                    isaPkg::OpStore, isaPkg::OpBranch: begin
                        nextState = corePkg::Execute;
                    end
                    isaPkg::OpSystem: begin
                        nextState = corePkg::Halted;
                        retire    = isEbreak;
                        badOp     = !isEbreak;
                    end
                    default: begin
                        nextState = corePkg::Halted;
                        badOp     = 1'b1;
                    end
                endcase
            end
            corePkg::Execute: begin
                aluSrcImm = (opcode != isaPkg::OpReg) && (opcode != isaPkg::OpBranch);
                if (opcode == isaPkg::OpBranch) begin
                    pcBranch  = taken;
                    pcInc     = !taken;
                    retire    = 1'b1;
                    nextState = corePkg::Fetch;
                end else begin
                    pcInc     = 1'b1;
                    nextState = isMemOp ? corePkg::Memory : corePkg::WriteBack;
                end
            end
            corePkg::Memory: begin
                memAddr = aluOutReg;
                if (opcode == isaPkg::OpStore) begin
                    memWe     = 1'b1;
                    retire    = 1'b1;
                    nextState = corePkg::Fetch;
                end else begin
                    nextState = corePkg::WriteBack;
                end
            end
            corePkg::WriteBack: begin
                regWrite  = 1'b1;
                memToReg  = (opcode == isaPkg::OpLoad);
                retire    = 1'b1;
                nextState = corePkg::Fetch;
            end
            default: begin
                // Halted until reset
                nextState = corePkg::Halted;
            end
        endcase
    end

    assign halted = (state == corePkg::Halted);

endmodule

// File: source/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic                            start,
    input  logic                            progWe,
    input  logic [corePkg::memAddrBits-1:0] progAddr,
    input  logic [corePkg::xlen-1:0]        progData,
    input  logic [corePkg::regAddrBits-1:0] dbgAddr,
    output logic [corePkg::xlen-1:0]        dbgData,
    output logic                            halted,
    output logic                            illegal,
    output logic [corePkg::xlen-1:0]        retired
);

    logic [corePkg::regAddrBits-1:0] rs1, rs2, rd;
    logic [corePkg::xlen-1:0]        memAddr, memRdata, imm;
    logic [corePkg::xlen-1:0]        readData1, readData2, aluB, aluResult;
    logic [corePkg::xlen-1:0]        aluOutReg, branchTarget, pc;
    isaPkg::opcodeT                  opcode;
    isaPkg::aluOpT                   aluOpSel;
    logic                            isEbreak, aluZero, branchNe;
    logic                            memWe, irLoad, regWrite, memToReg, aluSrcImm;
    logic                            pcInc, pcBranch, retire;

    // Second ALU operand
    assign aluB = aluSrcImm ? imm : readData2;

    controlFsm i_controlFsm (
        .clk(clk), .arstN(arstN), .start(start),
        .opcode(opcode), .isEbreak(isEbreak), .aluZero(aluZero), .branchNe(branchNe),
        .aluResult(aluResult), .pc(pc), .imm(imm), .readData1(readData1),
        .memAddr(memAddr), .memWe(memWe), .irLoad(irLoad),
        .regWrite(regWrite), .memToReg(memToReg), .aluSrcImm(aluSrcImm),
        .pcInc(pcInc), .pcBranch(pcBranch), .retire(retire),
        .aluOutReg(aluOutReg), .branchTarget(branchTarget),
        .halted(halted), .illegal(illegal)
    );

    pcCounter i_pcCounter (
        .clk(clk), .arstN(arstN),
        .pcInc(pcInc), .pcBranch(pcBranch), .retire(retire),
        .branchTarget(branchTarget), .pc(pc), .retired(retired)
    );

    instrDecode i_instrDecode (
        .clk(clk), .arstN(arstN), .irLoad(irLoad), .memData(memRdata),
        .rs1(rs1), .rs2(rs2), .rd(rd), .opcode(opcode), .imm(imm),
        .aluOpSel(aluOpSel), .branchNe(branchNe), .isEbreak(isEbreak)
    );

    regFile i_regFile (
        .clk(clk), .arstN(arstN), .rs1(rs1), .rs2(rs2), .rd(rd),
        .regWrite(regWrite), .memToReg(memToReg),
        .aluResult(aluOutReg), .memData(memRdata),
        .readData1(readData1), .readData2(readData2),
        .dbgAddr(dbgAddr), .dbgData(dbgData)
    );

    alu i_alu (
        .op(aluOpSel), .a(readData1), .b(aluB),
        .result(aluResult), .zero(aluZero)
    );

    unifiedMemory i_unifiedMemory (
        .clk(clk), .arstN(arstN),
        .addr(memAddr), .we(memWe), .wdata(readData2), .rdata(memRdata),
        .progWe(progWe), .progAddr(progAddr), .progData(progData)
    );

endmodule

// File: tests/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;

    logic                            clk;
    logic                            arstN;
    logic                            start;
    logic                            progWe;
    logic [corePkg::memAddrBits-1:0] progAddr;
    logic [corePkg::xlen-1:0]        progData;
    logic [corePkg::regAddrBits-1:0] dbgAddr;
    logic [corePkg::xlen-1:0]        dbgData;
    logic                            halted;
    logic                            illegal;
    logic [corePkg::xlen-1:0]        retired;

    logic [31:0] prog [$];
    logic [31:0] expRegs [32];
    logic [31:0] expRetired;
    logic        expIllegal;
    int          errors;
    int          checks;
    int          cycleCount;
    int          cycleLimit;
    logic        running;

    cpuTop i_cpuTop (
        .clk(clk), .arstN(arstN), .start(start),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .dbgAddr(dbgAddr), .dbgData(dbgData),
        .halted(halted), .illegal(illegal), .retired(retired)
    );

    always #2 clk = ~clk;

    // Watchdog counts only while a program runs
    always @(posedge clk) begin
        if (running) begin
            cycleCount = cycleCount + 1;
            if (cycleCount > cycleLimit) begin
                $display("Timeout: the core did not halt within %0d run cycles", cycleLimit);
                $display("TEST FAILED");
                $finish;
            end
        end
    end

    // --------------------
    // Instruction encoders
    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3,
                                          input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), isaPkg::OpReg};
    endfunction

    function automatic logic [31:0] iType(input logic [6:0] op, input logic [2:0] f3,
                                          input int rd, input int rs1, input logic [31:0] imm);
        return {imm[11:0], 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] addi(input int rd, input int rs1, input logic [31:0] imm);
        return iType(isaPkg::OpImm, isaPkg::f3AddSub, rd, rs1, imm);
    endfunction

    function automatic logic [31:0] sType(input int rs2, input int rs1, input logic [31:0] imm);
        return {imm[11:5], 5'(rs2), 5'(rs1), isaPkg::f3Word, imm[4:0], isaPkg::OpStore};
    endfunction

    function automatic logic [31:0] bType(input logic [2:0] f3, input int rs1, input int rs2,
                                          input logic [31:0] off);
        return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11], isaPkg::OpBranch};
    endfunction

    // --------------------
    // Instruction-level reference model
    task automatic modelRun();
        logic [31:0] mem [256];
        logic [31:0] pcM, nextPc, ins, a, b, ea;
        logic        done;
        int          steps;
        foreach (mem[i]) mem[i] = (i < prog.size()) ? prog[i] : '0;
        foreach (expRegs[i]) expRegs[i] = '0;
        expRetired = '0;
        expIllegal = 1'b0;
        pcM = corePkg::resetPc;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 1000) begin
            ins = mem[pcM[9:2]];
            a = expRegs[ins[19:15]];
            b = expRegs[ins[24:20]];
            nextPc = pcM + 32'd4;
            steps++;
            expRetired++;
            case (ins[6:0])
                isaPkg::OpReg: begin
                    case (ins[14:12])
                        isaPkg::f3AddSub: expRegs[ins[11:7]] = ins[30] ? a - b : a + b;
                        isaPkg::f3Slt: expRegs[ins[11:7]] = {31'b0, $signed(a) < $signed(b)};
                        isaPkg::f3Xor: expRegs[ins[11:7]] = a ^ b;
                        isaPkg::f3Or: expRegs[ins[11:7]] = a | b;
                        default: expRegs[ins[11:7]] = a & b;
                    endcase
                end
                isaPkg::OpImm: expRegs[ins[11:7]] = a + {{20{ins[31]}}, ins[31:20]};
                isaPkg::OpLoad: begin
                    ea = a + {{20{ins[31]}}, ins[31:20]};
                    expRegs[ins[11:7]] = mem[ea[9:2]];
                end
                isaPkg::OpStore: begin
                    ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    mem[ea[9:2]] = b;
                end
                isaPkg::OpBranch: begin
                    if ((a == b) != ins[12]) begin
                        nextPc = pcM + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                default: begin
                    done = 1'b1;
                    // EBREAK retires, anything else is illegal
                    if (ins != isaPkg::ebreakWord) begin
                        expIllegal = 1'b1;
                        expRetired--;
                    end
                end
            endcase
            expRegs[0] = '0;
            pcM = nextPc;
        end
    endtask

    // --------------------
    // Sequencing and checks
    task automatic expectEq(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", what, got, exp);
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        arstN <= 1'b0;
        repeat (8) @(posedge clk);
        arstN <= 1'b1;
    endtask

    task automatic checkResults(input string name);
        expectEq({name, " illegal"}, {31'b0, illegal}, {31'b0, expIllegal});
        expectEq({name, " retired"}, retired, expRetired);
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            dbgAddr <= 5'(r);
            @(negedge clk);
            expectEq($sformatf("%s dbgData x%0d", name, r), dbgData, expRegs[r]);
        end
    endtask

    task automatic runProgram(input string name);
        modelRun();
        cycleLimit = cycleLimit + 5 * int'(expRetired + expIllegal) + 20;
        applyReset();
        foreach (prog[i]) begin
            @(posedge clk);
            progWe   <= 1'b1;
            progAddr <= 8'(i);
            progData <= prog[i];
        end
        @(posedge clk);
        progWe <= 1'b0;
        start  <= 1'b1;
        @(posedge clk);
        start   <= 1'b0;
        running = 1'b1;
        while (!halted) @(negedge clk);
        running = 1'b0;
        checkResults(name);
    endtask

    initial begin
        clk = 1'b0;
        arstN = 1'b0;
        start = 1'b0;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        dbgAddr = '0;
        errors = 0;
        checks = 0;
        cycleCount = 0;
        cycleLimit = 0;
        running = 1'b0;
        void'($urandom(32'h6097_ca59));

        applyReset();
        @(negedge clk);
        foreach (expRegs[i]) expRegs[i] = '0;
        expRetired = '0;
        expIllegal = 1'b0;
        expectEq("reset halted", {31'b0, halted}, 32'h0);
        checkResults("reset");

        // Random immediates, then every R-type op with signed SLT corners
        prog = {addi(1, 0, $urandom), addi(2, 0, $urandom), addi(3, 0, -7), addi(4, 0, 3)};
        prog.push_back(addi(5, 1, $urandom));
        prog.push_back(rType(isaPkg::f7Base, isaPkg::f3AddSub, 10, 1, 2));
        prog.push_back(rType(isaPkg::f7Sub, isaPkg::f3AddSub, 11, 1, 2));
        prog.push_back(rType(isaPkg::f7Base, isaPkg::f3And, 12, 5, 2));
        prog.push_back(rType(isaPkg::f7Base, isaPkg::f3Or, 13, 5, 2));
        prog.push_back(rType(isaPkg::f7Base, isaPkg::f3Xor, 14, 5, 2));
        prog.push_back(rType(isaPkg::f7Base, isaPkg::f3Slt, 15, 1, 2));
        prog.push_back(rType(isaPkg::f7Base, isaPkg::f3Slt, 16, 3, 4));
        prog.push_back(rType(isaPkg::f7Base, isaPkg::f3Slt, 17, 4, 3));
        prog.push_back(rType(isaPkg::f7Base, isaPkg::f3Slt, 18, 3, 3));
        prog.push_back(isaPkg::ebreakWord);
        runProgram("alu");

        prog = {addi(0, 0, 123), rType(isaPkg::f7Base, isaPkg::f3AddSub, 5, 0, 0)};
        prog.push_back(addi(6, 0, 9));
        prog.push_back(rType(isaPkg::f7Base, isaPkg::f3Or, 7, 0, 6));
        prog.push_back(addi(8, 0, -1));
        prog.push_back(rType(isaPkg::f7Base, isaPkg::f3AddSub, 0, 8, 8));
        prog.push_back(isaPkg::ebreakWord);
        runProgram("x0");

        // Stores and loads in the data area above the code
        prog = {addi(1, 0, 32'h300), addi(2, 0, $urandom), addi(3, 0, $urandom)};
        prog.push_back(sType(2, 1, 0));
        prog.push_back(sType(3, 1, 4));
        prog.push_back(iType(isaPkg::OpLoad, isaPkg::f3Word, 4, 1, 0));
        prog.push_back(iType(isaPkg::OpLoad, isaPkg::f3Word, 5, 1, 4));
        prog.push_back(iType(isaPkg::OpLoad, isaPkg::f3Word, 6, 1, 8));
        prog.push_back(addi(8, 1, 16));
        prog.push_back(iType(isaPkg::OpLoad, isaPkg::f3Word, 9, 8, -16));
        prog.push_back(isaPkg::ebreakWord);
        runProgram("mem");

        // Counted loop, then one taken and one not-taken BEQ
        prog = {addi(1, 0, 5), addi(2, 0, 0), addi(2, 2, 3), addi(1, 1, -1)};
        prog.push_back(bType(isaPkg::f3Bne, 1, 0, -8));
        prog.push_back(bType(isaPkg::f3Beq, 2, 2, 8));
        prog.push_back(addi(3, 0, 99));
        prog.push_back(bType(isaPkg::f3Beq, 1, 2, 8));
        prog.push_back(addi(4, 0, 7));
        prog.push_back(isaPkg::ebreakWord);
        runProgram("branch");

        prog = {addi(1, 0, 11), addi(2, 0, 22), 32'h0000_007F, addi(3, 0, 33)};
        prog.push_back(isaPkg::ebreakWord);
        runProgram("illegal");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
source/isaPkg.sv
source/corePkg.sv
source/regFile.sv
source/alu.sv
source/instrDecode.sv
source/pcCounter.sv
source/unifiedMemory.sv
source/controlFsm.sv
source/cpuTop.sv
tests/cpuTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and pass only if the testbench reports a pass

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module cpuTb \
    -f project.f -o cpuSim &&
simOut="$(./obj_dir/cpuSim)" &&
echo "$simOut" &&
echo "$simOut" | grep -q "TEST PASSED" &&
exit 0 || exit 1
